// File: hw/bsplit_cfg.svh
`ifndef BSPLIT_CFG_SVH
`define BSPLIT_CFG_SVH

// --------------------
// Bus widths
// --------------------

// Address width in bits
`define BSPLIT_ADDR_W 32

// Data width in bits, strobe is one bit per byte
`define BSPLIT_DATA_W 32

// Transaction ID width in bits
`define BSPLIT_ID_W 4

// --------------------
// Queue sizing
// --------------------

// Bursts that may be outstanding per direction
`define BSPLIT_MAX_TXNS 4

`endif

// File: hw/bsplit_pkg.sv
`include "bsplit_cfg.svh"

package bsplit_pkg;

  // --------------------
  // Encodings
  // --------------------
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  // Splitter FSM
  typedef enum logic {
    IDLE,
    BUSY
  } ax_state_e;

  // Response path FSM, shared by R and B
  typedef enum logic {
    PASS,
    HOLD
  } hold_state_e;

  typedef logic [7:0] len_t;

  // --------------------
  // Channel payloads
  // --------------------
  typedef struct packed {
    logic [`BSPLIT_ID_W-1:0]   id;
    logic [`BSPLIT_ADDR_W-1:0] addr;
    len_t                      len;
    logic [2:0]                size;
    burst_e                    burst;
  } ax_chan_t;

  typedef struct packed {
    logic [`BSPLIT_DATA_W-1:0]   data;
    logic [`BSPLIT_DATA_W/8-1:0] strb;
    logic                        last;
  } w_chan_t;

  typedef struct packed {
    logic [`BSPLIT_ID_W-1:0] id;
    resp_e                   resp;
  } b_chan_t;

  typedef struct packed {
    logic [`BSPLIT_ID_W-1:0]   id;
    logic [`BSPLIT_DATA_W-1:0] data;
    resp_e                     resp;
    logic                      last;
  } r_chan_t;

endpackage

// File: hw/ax_splitter.sv
`timescale 1ns/1ps
`include "bsplit_cfg.svh"

module ax_splitter (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  input  bsplit_pkg::ax_chan_t ax_i,
  input  logic                 ax_valid_i,
  output logic                 ax_ready_o,

  output bsplit_pkg::ax_chan_t ax_o,
  output logic                 ax_valid_o,
  input  logic                 ax_ready_i,

  output bsplit_pkg::len_t     push_len_o,
  output logic                 push_valid_o,
  input  logic                 push_ready_i
);

  localparam int ADDR_W = `BSPLIT_ADDR_W;

  bsplit_pkg::ax_state_e state_q, state_d;
  bsplit_pkg::ax_chan_t  ax_q, ax_d;

  // Address of the following beat, FIXED bursts keep the address
  function automatic logic [ADDR_W-1:0] next_addr(input bsplit_pkg::ax_chan_t ax);
    logic [ADDR_W-1:0] step;
    step = ADDR_W'(1) << ax.size;
    if (ax.burst == bsplit_pkg::BURST_INCR) begin
      next_addr = ax.addr + step;
    end else begin
      next_addr = ax.addr;
    end
  endfunction

  // Original length goes to the queue unchanged
  assign push_len_o = ax_i.len;

  always_comb begin
    state_d      = state_q;
    ax_d         = ax_q;
    ax_o         = ax_q;
    ax_o.len     = '0;
    ax_valid_o   = 1'b0;
    ax_ready_o   = 1'b0;
    push_valid_o = 1'b0;

    case (state_q)
      bsplit_pkg::IDLE: begin
        if (ax_valid_i && push_ready_i) begin
          if (ax_i.len == '0) begin
            // Single beat, straight through
            ax_o       = ax_i;
            ax_valid_o = 1'b1;
            if (ax_ready_i) begin
              push_valid_o = 1'b1;
              ax_ready_o   = 1'b1;
            end
          end else begin
            // Take the burst and offer its first beat right away
            ax_d         = ax_i;
            push_valid_o = 1'b1;
            ax_ready_o   = 1'b1;
            ax_o         = ax_i;
            ax_o.len     = '0;
            ax_valid_o   = 1'b1;
            if (ax_ready_i) begin
              ax_d.len  = ax_i.len - 8'd1;
              ax_d.addr = next_addr(ax_i);
            end
            state_d = bsplit_pkg::BUSY;
          end
        end
      end
      bsplit_pkg::BUSY: begin
        ax_valid_o = 1'b1;
        if (ax_ready_i) begin
          if (ax_q.len == '0) begin
            state_d = bsplit_pkg::IDLE;
          end else begin
            ax_d.len  = ax_q.len - 8'd1;
            ax_d.addr = next_addr(ax_q);
          end
        end
      end
      default: begin
        state_d = bsplit_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= bsplit_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Stored burst, len counts the beats still to send minus one
  always_ff @(posedge clk_i) begin
    ax_q <= ax_d;
  end

endmodule

// File: hw/burst_len_queue.sv
`timescale 1ns/1ps
`include "bsplit_cfg.svh"

module burst_len_queue (
  input  logic             clk_i,
  input  logic             rst_n_i,

  input  bsplit_pkg::len_t push_len_i,
  input  logic             push_valid_i,
  output logic             push_ready_o,

  output logic             head_valid_o,
  output bsplit_pkg::len_t remaining_o,
  input  logic             dec_i
);

  localparam int DEPTH = `BSPLIT_MAX_TXNS;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  bsplit_pkg::len_t mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  bsplit_pkg::len_t beat_q;
  logic             push;
  logic             pop;
  logic             dec;

  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  assign head_valid_o = (count_q != '0);
  assign remaining_o  = mem_q[rd_ptr_q] - beat_q;

  assign push = push_valid_i && push_ready_o;
  assign dec  = dec_i && head_valid_o;
  // Last beat of the head burst retires the entry
  assign pop  = dec && (remaining_o == '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      beat_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
        beat_q   <= '0;
      end else if (dec) begin
        beat_q <= beat_q + 8'd1;
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_len_i;
    end
  end

endmodule

// File: hw/r_last_gen.sv
`timescale 1ns/1ps

module r_last_gen (
  input  logic                clk_i,
  input  logic                rst_n_i,

  input  bsplit_pkg::r_chan_t mst_r_i,
  input  logic                mst_r_valid_i,
  output logic                mst_r_ready_o,

  output bsplit_pkg::r_chan_t slv_r_o,
  output logic                slv_r_valid_o,
  input  logic                slv_r_ready_i,

  input  logic                head_valid_i,
  input  bsplit_pkg::len_t    remaining_i,
  output logic                dec_o
);

  bsplit_pkg::hold_state_e state_q, state_d;
  logic                    last_q, last_d;

  always_comb begin
    state_d       = state_q;
    last_d        = last_q;
    slv_r_o       = mst_r_i;
    slv_r_o.last  = 1'b0;
    slv_r_valid_o = 1'b0;
    mst_r_ready_o = 1'b0;
    dec_o         = 1'b0;

    case (state_q)
      bsplit_pkg::PASS: begin
        // Need the head length before the beat can go up
        if (mst_r_valid_i && head_valid_i) begin
          last_d        = (remaining_i == '0);
          slv_r_o.last  = last_d;
          slv_r_valid_o = 1'b1;
          dec_o         = 1'b1;
          if (slv_r_ready_i) begin
            mst_r_ready_o = 1'b1;
          end else begin
            state_d = bsplit_pkg::HOLD;
          end
        end
      end
      bsplit_pkg::HOLD: begin
        // Counter already moved on, so last comes from the register
        slv_r_o.last  = last_q;
        slv_r_valid_o = mst_r_valid_i;
        if (mst_r_valid_i && slv_r_ready_i) begin
          mst_r_ready_o = 1'b1;
          state_d       = bsplit_pkg::PASS;
        end
      end
      default: begin
        state_d = bsplit_pkg::PASS;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= bsplit_pkg::PASS;
      last_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      last_q  <= last_d;
    end
  end

endmodule

// File: hw/b_merge.sv
`timescale 1ns/1ps

module b_merge (
  input  logic                clk_i,
  input  logic                rst_n_i,

  input  bsplit_pkg::b_chan_t mst_b_i,
  input  logic                mst_b_valid_i,
  output logic                mst_b_ready_o,

  output bsplit_pkg::b_chan_t slv_b_o,
  output logic                slv_b_valid_o,
  input  logic                slv_b_ready_i,

  input  logic                head_valid_i,
  input  bsplit_pkg::len_t    remaining_i,
  output logic                dec_o
);

  bsplit_pkg::hold_state_e state_q, state_d;
  logic                    err_q, err_d;
  bsplit_pkg::resp_e       resp_q, resp_d;
  logic                    beat_err;
  bsplit_pkg::resp_e       merged;

  // SLVERR and DECERR both count as a failed beat
  assign beat_err = (mst_b_i.resp == bsplit_pkg::RESP_SLVERR) ||
                    (mst_b_i.resp == bsplit_pkg::RESP_DECERR);
  assign merged   = (err_q || beat_err) ? bsplit_pkg::RESP_SLVERR : mst_b_i.resp;

  always_comb begin
    state_d       = state_q;
    err_d         = err_q;
    resp_d        = resp_q;
    slv_b_o       = mst_b_i;
    slv_b_valid_o = 1'b0;
    mst_b_ready_o = 1'b0;
    dec_o         = 1'b0;

    case (state_q)
      bsplit_pkg::PASS: begin
        if (mst_b_valid_i && head_valid_i) begin
          dec_o = 1'b1;
          if (remaining_i != '0) begin
            // Intermediate beat is swallowed here
            mst_b_ready_o = 1'b1;
            err_d         = err_q || beat_err;
          end else begin
            slv_b_o.resp  = merged;
            slv_b_valid_o = 1'b1;
            err_d         = 1'b0;
            if (slv_b_ready_i) begin
              mst_b_ready_o = 1'b1;
            end else begin
              resp_d  = merged;
              state_d = bsplit_pkg::HOLD;
            end
          end
        end
      end
      bsplit_pkg::HOLD: begin
        slv_b_o.resp  = resp_q;
        slv_b_valid_o = mst_b_valid_i;
        if (mst_b_valid_i && slv_b_ready_i) begin
          mst_b_ready_o = 1'b1;
          state_d       = bsplit_pkg::PASS;
        end
      end
      default: begin
        state_d = bsplit_pkg::PASS;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= bsplit_pkg::PASS;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      err_q   <= err_d;
    end
  end

  // Merged response kept while upstream stalls
  always_ff @(posedge clk_i) begin
    resp_q <= resp_d;
  end

endmodule

// File: hw/burst_splitter_top.sv
`timescale 1ns/1ps

module burst_splitter_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // Upstream side
  input  bsplit_pkg::ax_chan_t slv_aw_i,
  input  logic                 slv_aw_valid_i,
  output logic                 slv_aw_ready_o,
  input  bsplit_pkg::w_chan_t  slv_w_i,
  input  logic                 slv_w_valid_i,
  output logic                 slv_w_ready_o,
  output bsplit_pkg::b_chan_t  slv_b_o,
  output logic                 slv_b_valid_o,
  input  logic                 slv_b_ready_i,
  input  bsplit_pkg::ax_chan_t slv_ar_i,
  input  logic                 slv_ar_valid_i,
  output logic                 slv_ar_ready_o,
  output bsplit_pkg::r_chan_t  slv_r_o,
  output logic                 slv_r_valid_o,
  input  logic                 slv_r_ready_i,

  // Downstream side
  output bsplit_pkg::ax_chan_t mst_aw_o,
  output logic                 mst_aw_valid_o,
  input  logic                 mst_aw_ready_i,
  output bsplit_pkg::w_chan_t  mst_w_o,
  output logic                 mst_w_valid_o,
  input  logic                 mst_w_ready_i,
  input  bsplit_pkg::b_chan_t  mst_b_i,
  input  logic                 mst_b_valid_i,
  output logic                 mst_b_ready_o,
  output bsplit_pkg::ax_chan_t mst_ar_o,
  output logic                 mst_ar_valid_o,
  input  logic                 mst_ar_ready_i,
  input  bsplit_pkg::r_chan_t  mst_r_i,
  input  logic                 mst_r_valid_i,
  output logic                 mst_r_ready_o
);

  bsplit_pkg::len_t aw_push_len;
  logic             aw_push_valid;
  logic             aw_push_ready;
  logic             b_head_valid;
  bsplit_pkg::len_t b_remaining;
  logic             b_dec;

  bsplit_pkg::len_t ar_push_len;
  logic             ar_push_valid;
  logic             ar_push_ready;
  logic             r_head_valid;
  bsplit_pkg::len_t r_remaining;
  logic             r_dec;

  // --------------------
  // Write path
  // --------------------
  ax_splitter i_aw_splitter (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ax_i         (slv_aw_i),
    .ax_valid_i   (slv_aw_valid_i),
    .ax_ready_o   (slv_aw_ready_o),
    .ax_o         (mst_aw_o),
    .ax_valid_o   (mst_aw_valid_o),
    .ax_ready_i   (mst_aw_ready_i),
    .push_len_o   (aw_push_len),
    .push_valid_o (aw_push_valid),
    .push_ready_i (aw_push_ready)
  );

  burst_len_queue i_aw_len_queue (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_len_i   (aw_push_len),
    .push_valid_i (aw_push_valid),
    .push_ready_o (aw_push_ready),
    .head_valid_o (b_head_valid),
    .remaining_o  (b_remaining),
    .dec_i        (b_dec)
  );

  // Every downstream write is a single beat
  always_comb begin
    mst_w_o      = slv_w_i;
    mst_w_o.last = 1'b1;
  end
  assign mst_w_valid_o = slv_w_valid_i;
  assign slv_w_ready_o = mst_w_ready_i;

  b_merge i_b_merge (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .mst_b_i       (mst_b_i),
    .mst_b_valid_i (mst_b_valid_i),
    .mst_b_ready_o (mst_b_ready_o),
    .slv_b_o       (slv_b_o),
    .slv_b_valid_o (slv_b_valid_o),
    .slv_b_ready_i (slv_b_ready_i),
    .head_valid_i  (b_head_valid),
    .remaining_i   (b_remaining),
    .dec_o         (b_dec)
  );

  // --------------------
  // Read path
  // --------------------
  ax_splitter i_ar_splitter (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ax_i         (slv_ar_i),
    .ax_valid_i   (slv_ar_valid_i),
    .ax_ready_o   (slv_ar_ready_o),
    .ax_o         (mst_ar_o),
    .ax_valid_o   (mst_ar_valid_o),
    .ax_ready_i   (mst_ar_ready_i),
    .push_len_o   (ar_push_len),
    .push_valid_o (ar_push_valid),
    .push_ready_i (ar_push_ready)
  );

  burst_len_queue i_ar_len_queue (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_len_i   (ar_push_len),
    .push_valid_i (ar_push_valid),
    .push_ready_o (ar_push_ready),
    .head_valid_o (r_head_valid),
    .remaining_o  (r_remaining),
    .dec_i        (r_dec)
  );

  r_last_gen i_r_last_gen (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .mst_r_i       (mst_r_i),
    .mst_r_valid_i (mst_r_valid_i),
    .mst_r_ready_o (mst_r_ready_o),
    .slv_r_o       (slv_r_o),
    .slv_r_valid_o (slv_r_valid_o),
    .slv_r_ready_i (slv_r_ready_i),
    .head_valid_i  (r_head_valid),
    .remaining_i   (r_remaining),
    .dec_o         (r_dec)
  );

endmodule

// File: tests/tb_axi_responder.sv
`timescale 1ns/1ps
`include "bsplit_cfg.svh"

module tb_axi_responder #(
  parameter logic [`BSPLIT_ADDR_W-1:0] DATA_KEY = '0,
  parameter logic [`BSPLIT_ADDR_W-1:0] ERR_BASE = '1
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  bsplit_pkg::ax_chan_t aw_i,
  input  logic                 aw_valid_i,
  output logic                 aw_ready_o,
  input  bsplit_pkg::w_chan_t  w_i,
  input  logic                 w_valid_i,
  output logic                 w_ready_o,
  output bsplit_pkg::b_chan_t  b_o,
  output logic                 b_valid_o,
  input  logic                 b_ready_i,
  input  bsplit_pkg::ax_chan_t ar_i,
  input  logic                 ar_valid_i,
  output logic                 ar_ready_o,
  output bsplit_pkg::r_chan_t  r_o,
  output logic                 r_valid_o,
  input  logic                 r_ready_i
);

  localparam int DATA_W    = `BSPLIT_DATA_W;
  localparam int LOG_DEPTH = 64;

  // Requests waiting for an answer with the oldest first
  bsplit_pkg::ax_chan_t ar_q [$];
  bsplit_pkg::ax_chan_t aw_q [$];
  bsplit_pkg::w_chan_t  w_q [$];
  bsplit_pkg::b_chan_t  b_q [$];

  // Everything seen downstream for the testbench to check
  bsplit_pkg::ax_chan_t ar_log [LOG_DEPTH];
  bsplit_pkg::ax_chan_t aw_log [LOG_DEPTH];
  bsplit_pkg::w_chan_t  w_log [LOG_DEPTH];
  int                   ar_cnt;
  int                   aw_cnt;
  int                   w_cnt;

  // --------------------
  // Handshakes
  // --------------------
  always @(posedge clk_i) begin
    bsplit_pkg::ax_chan_t aw;
    bsplit_pkg::b_chan_t  b;
    if (!rst_n_i) begin
      ar_q.delete();
      aw_q.delete();
      w_q.delete();
      b_q.delete();
      ar_cnt = 0;
      aw_cnt = 0;
      w_cnt  = 0;
    end else begin
      if (ar_valid_i && ar_ready_o) begin
        ar_q.push_back(ar_i);
        ar_log[ar_cnt] = ar_i;
        ar_cnt++;
      end
      if (r_valid_o && r_ready_i) begin
        void'(ar_q.pop_front());
      end
      if (aw_valid_i && aw_ready_o) begin
        aw_q.push_back(aw_i);
        aw_log[aw_cnt] = aw_i;
        aw_cnt++;
      end
      if (w_valid_i && w_ready_o) begin
        w_q.push_back(w_i);
        w_log[w_cnt] = w_i;
        w_cnt++;
      end
      if (b_valid_o && b_ready_i) begin
        void'(b_q.pop_front());
      end
      // One B per address and data pair in order
      while (aw_q.size() > 0 && w_q.size() > 0) begin
        aw = aw_q.pop_front();
        void'(w_q.pop_front());
        b.id   = aw.id;
        b.resp = (aw.addr >= ERR_BASE) ? bsplit_pkg::RESP_SLVERR : bsplit_pkg::RESP_OKAY;
        b_q.push_back(b);
      end
    end
  end

  // --------------------
  // Outputs change on the falling edge
  // --------------------
  initial begin
    aw_ready_o <= 1'b0;
    w_ready_o  <= 1'b0;
    ar_ready_o <= 1'b0;
    b_valid_o  <= 1'b0;
    r_valid_o  <= 1'b0;
    b_o        <= '0;
    r_o        <= '0;
    forever begin
      @(negedge clk_i);
      if (!rst_n_i) begin
        aw_ready_o <= 1'b0;
        w_ready_o  <= 1'b0;
        ar_ready_o <= 1'b0;
        b_valid_o  <= 1'b0;
        r_valid_o  <= 1'b0;
      end else begin
        aw_ready_o <= 1'($urandom);
        w_ready_o  <= 1'($urandom);
        ar_ready_o <= 1'($urandom);
        b_valid_o  <= (b_q.size() != 0);
        r_valid_o  <= (ar_q.size() != 0);
        if (b_q.size() != 0) begin
          b_o <= b_q[0];
        end
        if (ar_q.size() != 0) begin
          // Read data is the address scrambled with a fixed key
          r_o.id   <= ar_q[0].id;
          r_o.data <= DATA_W'(ar_q[0].addr ^ DATA_KEY);
          r_o.resp <= bsplit_pkg::RESP_OKAY;
          r_o.last <= 1'b1;
        end
      end
    end
  end

endmodule

// File: tests/tb_burst_splitter.sv
`timescale 1ns/1ps
`include "bsplit_cfg.svh"

module tb_burst_splitter;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  localparam int ADDR_W       = `BSPLIT_ADDR_W;
  localparam int DATA_W       = `BSPLIT_DATA_W;
  localparam logic [ADDR_W-1:0] DATA_KEY  = 32'hA5C3_0F69;
  localparam logic [ADDR_W-1:0] ERR_BASE  = 32'hFFFF_FFF8;
  localparam logic [DATA_W-1:0] W_PATTERN = 32'h5A00_0000;
  localparam int IDLE_CYCLES  = 8;

  // Timeout allows every beat of every test a generous number of stall cycles
  localparam int NUM_BEATS       = 26;
  localparam int NUM_TESTS       = 8;
  localparam int CYCLES_PER_BEAT = 40;
  localparam int CYCLES_PER_TEST = 20;
  localparam int TIMEOUT_NS = (RESET_CYCLES + NUM_BEATS * CYCLES_PER_BEAT +
                               NUM_TESTS * CYCLES_PER_TEST) * CLK_PERIOD;

  logic                 clk_i;
  logic                 rst_n_i;
  bsplit_pkg::ax_chan_t slv_aw_i;
  logic                 slv_aw_valid_i;
  logic                 slv_aw_ready_o;
  bsplit_pkg::w_chan_t  slv_w_i;
  logic                 slv_w_valid_i;
  logic                 slv_w_ready_o;
  bsplit_pkg::b_chan_t  slv_b_o;
  logic                 slv_b_valid_o;
  logic                 slv_b_ready_i;
  bsplit_pkg::ax_chan_t slv_ar_i;
  logic                 slv_ar_valid_i;
  logic                 slv_ar_ready_o;
  bsplit_pkg::r_chan_t  slv_r_o;
  logic                 slv_r_valid_o;
  logic                 slv_r_ready_i;
  bsplit_pkg::ax_chan_t mst_aw_o;
  logic                 mst_aw_valid_o;
  logic                 mst_aw_ready_i;
  bsplit_pkg::w_chan_t  mst_w_o;
  logic                 mst_w_valid_o;
  logic                 mst_w_ready_i;
  bsplit_pkg::b_chan_t  mst_b_i;
  logic                 mst_b_valid_i;
  logic                 mst_b_ready_o;
  bsplit_pkg::ax_chan_t mst_ar_o;
  logic                 mst_ar_valid_o;
  logic                 mst_ar_ready_i;
  bsplit_pkg::r_chan_t  mst_r_i;
  logic                 mst_r_valid_i;
  logic                 mst_r_ready_o;

  int errors;
  int checks;
  int tests_run;

  burst_splitter_top i_burst_splitter_top (.*);

  tb_axi_responder #(
    .DATA_KEY (DATA_KEY),
    .ERR_BASE (ERR_BASE)
  ) i_responder (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .aw_i       (mst_aw_o),
    .aw_valid_i (mst_aw_valid_o),
    .aw_ready_o (mst_aw_ready_i),
    .w_i        (mst_w_o),
    .w_valid_i  (mst_w_valid_o),
    .w_ready_o  (mst_w_ready_i),
    .b_o        (mst_b_i),
    .b_valid_o  (mst_b_valid_i),
    .b_ready_i  (mst_b_ready_o),
    .ar_i       (mst_ar_o),
    .ar_valid_i (mst_ar_valid_o),
    .ar_ready_o (mst_ar_ready_i),
    .r_o        (mst_r_i),
    .r_valid_o  (mst_r_valid_i),
    .r_ready_i  (mst_r_ready_o)
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // --------------------
  // Expected values
  // --------------------
  function automatic bsplit_pkg::ax_chan_t make_ax(input logic [3:0] id,
                                                   input logic [ADDR_W-1:0] addr,
                                                   input bsplit_pkg::len_t len,
                                                   input logic [2:0] size,
                                                   input bsplit_pkg::burst_e burst);
    bsplit_pkg::ax_chan_t ax;
    ax.id    = `BSPLIT_ID_W'(id);
    ax.addr  = addr;
    ax.len   = len;
    ax.size  = size;
    ax.burst = burst;
    return ax;
  endfunction

  // INCR steps by the transfer size per beat and FIXED stays put
  function automatic logic [ADDR_W-1:0] beat_addr(input bsplit_pkg::ax_chan_t ax, input int i);
    if (ax.burst == bsplit_pkg::BURST_FIXED) begin
      return ax.addr;
    end
    return ax.addr + ADDR_W'(i) * (ADDR_W'(1) << ax.size);
  endfunction

  // --------------------
  // Compare tasks
  // --------------------
  task automatic compare_r(input bsplit_pkg::r_chan_t got, input bsplit_pkg::r_chan_t want,
                           input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAILED at %0t: %s R got id=%h data=%h resp=%0d last=%b", $time, what,
               got.id, got.data, got.resp, got.last);
      $display("  expected id=%h data=%h resp=%0d last=%b", want.id, want.data,
               want.resp, want.last);
    end
  endtask

  task automatic compare_b(input bsplit_pkg::b_chan_t got, input bsplit_pkg::b_chan_t want,
                           input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAILED at %0t: %s B got id=%h resp=%0d, expected id=%h resp=%0d", $time,
               what, got.id, got.resp, want.id, want.resp);
    end
  endtask

  task automatic compare_ax(input bsplit_pkg::ax_chan_t got, input bsplit_pkg::ax_chan_t want,
                            input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAILED at %0t: %s AX got id=%h addr=%h len=%0d size=%0d burst=%0d", $time,
               what, got.id, got.addr, got.len, got.size, got.burst);
      $display("  expected id=%h addr=%h len=%0d size=%0d burst=%0d", want.id, want.addr,
               want.len, want.size, want.burst);
    end
  endtask

  task automatic compare_w(input bsplit_pkg::w_chan_t got, input bsplit_pkg::w_chan_t want,
                           input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAILED at %0t: %s W got data=%h strb=%h last=%b, expected %h %h %b", $time,
               what, got.data, got.strb, got.last, want.data, want.strb, want.last);
    end
  endtask

  task automatic check_count(input string what, input int got, input int want);
    checks++;
    if (got != want) begin
      errors++;
      $display("FAILED at %0t: %s count is %0d, expected %0d", $time, what, got, want);
    end
  endtask

  // --------------------
  // Channel drivers
  // --------------------
  // DUT outputs settle after the falling edge and hold until the rising edge
  task automatic send_ar(input bsplit_pkg::ax_chan_t ax);
    logic accepted;
    @(negedge clk_i);
    slv_ar_i       = ax;
    slv_ar_valid_i = 1'b1;
    do begin
      #(CLK_PERIOD / 4);
      accepted = slv_ar_ready_o;
      @(negedge clk_i);
    end while (!accepted);
    slv_ar_valid_i = 1'b0;
  endtask

  task automatic send_aw(input bsplit_pkg::ax_chan_t ax);
    logic accepted;
    @(negedge clk_i);
    slv_aw_i       = ax;
    slv_aw_valid_i = 1'b1;
    do begin
      #(CLK_PERIOD / 4);
      accepted = slv_aw_ready_o;
      @(negedge clk_i);
    end while (!accepted);
    slv_aw_valid_i = 1'b0;
  endtask

  task automatic send_w(input bsplit_pkg::w_chan_t w);
    @(negedge clk_i);
    slv_w_i       = w;
    slv_w_valid_i = 1'b1;
    @(posedge clk_i);
    while (!slv_w_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    slv_w_valid_i = 1'b0;
  endtask

  task automatic recv_r(input bit rand_ready, output bsplit_pkg::r_chan_t beat);
    logic taken;
    do begin
      @(negedge clk_i);
      slv_r_ready_i = rand_ready ? 1'($urandom) : 1'b1;
      #(CLK_PERIOD / 4);
      taken = slv_r_valid_o && slv_r_ready_i;
      beat  = slv_r_o;
    end while (!taken);
    @(negedge clk_i);
    slv_r_ready_i = 1'b0;
  endtask

  task automatic recv_b(input bit rand_ready, output bsplit_pkg::b_chan_t resp);
    logic taken;
    do begin
      @(negedge clk_i);
      slv_b_ready_i = rand_ready ? 1'($urandom) : 1'b1;
      #(CLK_PERIOD / 4);
      taken = slv_b_valid_o && slv_b_ready_i;
      resp  = slv_b_o;
    end while (!taken);
    @(negedge clk_i);
    slv_b_ready_i = 1'b0;
  endtask

  // All downstream B of the burst are used up, so nothing more may come
  task automatic check_no_extra_b(input string name);
    slv_b_ready_i = 1'b1;
    checks++;
    repeat (IDLE_CYCLES) begin
      #(CLK_PERIOD / 4);
      if (slv_b_valid_o) begin
        errors++;
        $display("Test %s saw an extra B response upstream at %0t", name, $time);
      end
      @(negedge clk_i);
    end
    slv_b_ready_i = 1'b0;
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("Test %s passed", name);
    end else begin
      $display("Test %s failed, %0d checks wrong", name, errors - errors_before);
    end
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic run_read(input string name, input bsplit_pkg::ax_chan_t ax,
                          input bit rand_ready);
    bsplit_pkg::r_chan_t  got;
    bsplit_pkg::r_chan_t  want;
    bsplit_pkg::ax_chan_t want_ar;
    int                   first;
    int                   errors_before;
    errors_before = errors;
    first         = i_responder.ar_cnt;
    send_ar(ax);
    for (int i = 0; i <= int'(ax.len); i++) begin
      recv_r(rand_ready, got);
      want.id   = ax.id;
      want.data = DATA_W'(beat_addr(ax, i) ^ DATA_KEY);
      want.resp = bsplit_pkg::RESP_OKAY;
      want.last = (i == int'(ax.len));
      compare_r(got, want, name);
    end
    check_count({name, " downstream AR"}, i_responder.ar_cnt - first, int'(ax.len) + 1);
    for (int i = 0; i <= int'(ax.len); i++) begin
      want_ar      = ax;
      want_ar.addr = beat_addr(ax, i);
      want_ar.len  = '0;
      compare_ax(i_responder.ar_log[first + i], want_ar, name);
    end
    finish_test(name, errors_before);
  endtask

  task automatic run_write(input string name, input bsplit_pkg::ax_chan_t ax,
                           input bit rand_ready);
    bsplit_pkg::w_chan_t  w;
    bsplit_pkg::b_chan_t  got;
    bsplit_pkg::b_chan_t  want;
    bsplit_pkg::ax_chan_t want_aw;
    logic                 any_err;
    int                   aw_first;
    int                   w_first;
    int                   errors_before;
    errors_before = errors;
    aw_first      = i_responder.aw_cnt;
    w_first       = i_responder.w_cnt;
    any_err       = 1'b0;
    // Data goes first and the responder pairs it with the AW later
    for (int i = 0; i <= int'(ax.len); i++) begin
      w.data = W_PATTERN ^ DATA_W'(i);
      w.strb = '1;
      w.last = (i == int'(ax.len));
      send_w(w);
      if (beat_addr(ax, i) >= ERR_BASE) begin
        any_err = 1'b1;
      end
    end
    send_aw(ax);
    recv_b(rand_ready, got);
    want.id   = ax.id;
    want.resp = any_err ? bsplit_pkg::RESP_SLVERR : bsplit_pkg::RESP_OKAY;
    compare_b(got, want, name);
    check_no_extra_b(name);
    check_count({name, " downstream AW"}, i_responder.aw_cnt - aw_first, int'(ax.len) + 1);
    check_count({name, " downstream W"}, i_responder.w_cnt - w_first, int'(ax.len) + 1);
    for (int i = 0; i <= int'(ax.len); i++) begin
      want_aw      = ax;
      want_aw.addr = beat_addr(ax, i);
      want_aw.len  = '0;
      compare_ax(i_responder.aw_log[aw_first + i], want_aw, name);
      w.data = W_PATTERN ^ DATA_W'(i);
      w.strb = '1;
      w.last = 1'b1;
      compare_w(i_responder.w_log[w_first + i], w, name);
    end
    finish_test(name, errors_before);
  endtask

  initial begin
    void'($urandom(37751));
    errors         = 0;
    checks         = 0;
    tests_run      = 0;
    rst_n_i        = 1'b0;
    slv_aw_i       = '0;
    slv_aw_valid_i = 1'b0;
    slv_w_i        = '0;
    slv_w_valid_i  = 1'b0;
    slv_b_ready_i  = 1'b0;
    slv_ar_i       = '0;
    slv_ar_valid_i = 1'b0;
    slv_r_ready_i  = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    run_read("incr_read", make_ax(3, 32'h1000, 3, 2, bsplit_pkg::BURST_INCR), 1'b0);
    run_read("fixed_read", make_ax(5, 32'h2040, 2, 2, bsplit_pkg::BURST_FIXED), 1'b0);
    run_read("single_read", make_ax(1, 32'h3008, 0, 2, bsplit_pkg::BURST_INCR), 1'b0);
    run_write("single_write", make_ax(2, 32'h300C, 0, 2, bsplit_pkg::BURST_INCR), 1'b0);
    run_write("incr_write", make_ax(6, 32'h4000, 3, 2, bsplit_pkg::BURST_INCR), 1'b0);
    // Third and fourth beats fail while the fifth wraps to address zero and succeeds
    run_write("error_write", make_ax(7, ERR_BASE - 32'd8, 4, 2, bsplit_pkg::BURST_INCR),
              1'b0);
    run_read("incr_read_stall", make_ax(3, 32'h1000, 3, 2, bsplit_pkg::BURST_INCR), 1'b1);
    run_write("incr_write_stall", make_ax(6, 32'h4000, 3, 2, bsplit_pkg::BURST_INCR), 1'b1);

    $display("Tests run: %0d, checks: %0d, failed checks: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("Errors found");
    $finish;
  end

endmodule

// File: flist.f
+incdir+hw
hw/bsplit_pkg.sv
hw/ax_splitter.sv
hw/burst_len_queue.sv
hw/r_last_gen.sv
hw/b_merge.sv
hw/burst_splitter_top.sv
tests/tb_axi_responder.sv
tests/tb_burst_splitter.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f flist.f --top-module tb_burst_splitter -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Compilation failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" "$LOG"; then
  echo "Result: FAIL"
  exit 1
fi

echo "Result: PASS"
exit 0
